// ==== include/frv_cfg.svh ====
// Fetch front end configuration
// Bus width, reset PC, buffer depth, request limit

`ifndef FRV_CFG_SVH
`define FRV_CFG_SVH

// --------------------
// Datapath

`define FRV_XLEN            32              // Data and address width
`define FRV_PC_RESET        32'h8000_0000   // First fetch address

// --------------------
// Fetch resources

`define FRV_MAX_OUTSTANDING 3               // Requests in flight on the bus
`define FRV_BUF_HWORDS      4               // Buffer depth in 16-bit parcels

`endif

// ==== rtl/frv_bus_pkg.sv ====
// Instruction memory bus types
// Address, read data word, outstanding request counter

`include "frv_cfg.svh"

package frv_bus_pkg;

    // --------------------
    // Bus payload

    typedef logic [`FRV_XLEN-1:0] addr_t;   // Byte address kept word aligned on the bus
    typedef logic [`FRV_XLEN-1:0] word_t;   // One read data beat

    // --------------------
    // Bookkeeping

    // Holds 0..3 for up to FRV_MAX_OUTSTANDING
    typedef logic [1:0] req_cnt_t;

endpackage

// ==== rtl/frv_pipe_pkg.sv ====
// Fetch pipeline types
// Parcels, decode-side instruction, buffer fill level, fetch FSM states

`include "frv_cfg.svh"

package frv_pipe_pkg;

    // --------------------
    // Instruction data

    typedef logic [15:0]          hword_t;  // One compressed parcel
    typedef logic [`FRV_XLEN-1:0] instr_t;  // Upper half zero if compressed

    // Counts 0..FRV_BUF_HWORDS parcels
    typedef logic [2:0] fill_t;

    // --------------------
    // Fetch FSM

    typedef enum logic [1:0] {
        RUN,                                // Responses go to the buffer
        DISCARD,                            // Stale responses after a redirect
        MISALIGNED_FIRST                    // Next response gives its upper half only
    } fetch_state_t;

endpackage

// ==== rtl/frv_core_fetch_buffer.sv ====
// Fetch buffer of 16-bit parcels with per-parcel error bits
// Appends one or two parcels per response and presents
// compressed or full-width instructions at the head

`timescale 1ns/1ps

`include "frv_cfg.svh"

module frv_core_fetch_buffer
    import frv_bus_pkg::*, frv_pipe_pkg::*;
(
    input  logic    g_clk,
    input  logic    g_resetn,
    input  logic    flush,            // Drop all parcels
    input  logic    f_4byte,          // Write both halves of f_in
    input  logic    f_2byte,          // Write upper half of f_in
    input  logic    f_err,
    input  word_t   f_in,
    input  logic    buf_ready,        // Head consumed
    output logic    f_ready,
    output instr_t  buf_out,
    output logic    buf_err,
    output logic    buf_valid
);

    localparam int DEPTH = `FRV_BUF_HWORDS;

    hword_t           hw_q [DEPTH];   // Parcel 0 is the head
    hword_t           hw_d [DEPTH];
    logic [DEPTH-1:0] err_q;
    logic [DEPTH-1:0] err_d;
    fill_t            fill_q;
    fill_t            fill_d;
    fill_t            used;           // Parcels in the head instruction
    fill_t            base;           // First free slot after the shift
    fill_t            added;
    logic             head_4b;
    logic             consume;

    // --------------------
    // Head decode

    // An errored first parcel stands alone
    assign head_4b   = (hw_q[0][1:0] == 2'b11) && !err_q[0];
    assign used      = head_4b ? fill_t'(2) : fill_t'(1);
    assign buf_valid = (fill_q >= used);
    assign buf_out   = head_4b ? {hw_q[1], hw_q[0]} : instr_t'(hw_q[0]);
    assign buf_err   = err_q[0] | (head_4b & err_q[1]);
    assign consume   = buf_valid && buf_ready;

    // --------------------
    // Fill bookkeeping

    assign f_ready = (fill_q <= fill_t'(2));        // Room for a full word
    assign base    = consume ? fill_q - used : fill_q;
    assign added   = f_4byte ? fill_t'(2) : (f_2byte ? fill_t'(1) : fill_t'(0));
    assign fill_d  = base + added;

    // Shift out the head, then append behind what is left
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hw_d[i]  = hw_q[i];
            err_d[i] = err_q[i];
            if (consume) begin
                if (i + int'(used) < DEPTH) begin
                    hw_d[i]  = hw_q[i + int'(used)];
                    err_d[i] = err_q[i + int'(used)];
                end
            end
            if (f_4byte && fill_t'(i) == base) begin
                hw_d[i]  = f_in[15:0];              // Lower parcel first
                err_d[i] = f_err;
            end
            if (f_4byte && fill_t'(i) == base + fill_t'(1)) begin
                hw_d[i]  = f_in[31:16];
                err_d[i] = f_err;
            end
            if (f_2byte && fill_t'(i) == base) begin
                hw_d[i]  = f_in[31:16];             // Misaligned target half
                err_d[i] = f_err;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            fill_q <= '0;
        end else if (flush) begin
            fill_q <= '0;                           // Beats a same-cycle write
        end else begin
            fill_q <= fill_d;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < DEPTH; i++) begin
                hw_q[i] <= '0;
            end
            err_q <= '0;
        end else begin
            hw_q  <= hw_d;
            err_q <= err_d;
        end
    end

    // --------------------
    // Checks

    // Holds only if the fetch stage writes behind f_ready
    a_fill_bound : assert property (@(posedge g_clk) disable iff (!g_resetn)
        fill_q <= fill_t'(DEPTH))
        else $error("fetch buffer overfilled, fill %0d", fill_q);

    // Half writes come only from the misaligned first response
    a_one_strobe : assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(f_4byte && f_2byte))
        else $error("full and half parcel writes in the same cycle");

endmodule

// ==== rtl/frv_pipeline_fetch.sv ====
// Instruction fetch stage, top of the fetch front end
// Request address and gating, outstanding/discard counters,
// redirect and misaligned-target FSM, fetch buffer instance

`timescale 1ns/1ps

`include "frv_cfg.svh"

module frv_pipeline_fetch
    import frv_bus_pkg::*, frv_pipe_pkg::*;
(
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     cf_req,          // Redirect request, held until cf_ack
    input  addr_t    cf_target,
    output logic     cf_ack,
    output logic     imem_req,
    output addr_t    imem_addr,
    input  logic     imem_gnt,
    output logic     imem_ack,
    input  logic     imem_recv,
    input  logic     imem_error,
    input  word_t    imem_rdata,
    input  logic     s0_flush,        // Pulsed with the redirect
    input  logic     s1_busy,         // Decode stall
    output logic     s1_valid,
    output instr_t   s1_data,
    output logic     s1_error
);

    localparam req_cnt_t MAX_OUT = req_cnt_t'(`FRV_MAX_OUTSTANDING);

    fetch_state_t state_q;
    fetch_state_t state_d;
    req_cnt_t     out_q;              // Granted, not yet answered
    req_cnt_t     out_d;
    req_cnt_t     discard_q;          // Answers still to throw away
    logic         mis_pend_q;         // Target had bit 1 set
    logic         req_fire;
    logic         rsp_recv;
    logic         cf_change;
    logic         drop;
    logic         misaligned;
    logic         f_4byte;
    logic         f_2byte;
    logic         f_ready;
    logic         buf_valid;
    logic         buf_ready;

    // --------------------
    // Bus handshakes

    assign req_fire  = imem_req && imem_gnt;
    assign rsp_recv  = imem_recv && imem_ack;
    assign imem_ack  = f_ready;                     // Full buffer stalls memory
    assign cf_ack    = !imem_req || imem_gnt;       // No ungranted request pending
    assign cf_change = cf_req && cf_ack;

    assign out_d = out_q + req_cnt_t'(req_fire) - req_cnt_t'(rsp_recv);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            out_q <= '0;
        end else begin
            out_q <= out_d;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_addr <= addr_t'(`FRV_PC_RESET);
        end else if (cf_change) begin
            imem_addr <= {cf_target[`FRV_XLEN-1:2], 2'b00};   // Word of the target
        end else if (req_fire) begin
            imem_addr <= imem_addr + addr_t'(4);
        end
    end

    // Hold an ungranted request, else issue while space and limit allow
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req <= 1'b0;
        end else begin
            imem_req <= (imem_req && !imem_gnt) ||
                        ((f_ready || cf_change) && (out_d < MAX_OUT));
        end
    end

    // --------------------
    // Redirect / misalignment FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            DISCARD: begin
                if (rsp_recv && discard_q == req_cnt_t'(1)) begin
                    state_d = mis_pend_q ? MISALIGNED_FIRST : RUN;  // Last stale one
                end
            end
            MISALIGNED_FIRST: begin
                if (rsp_recv) begin
                    state_d = RUN;
                end
            end
            default: begin
            end
        endcase
        if (cf_change) begin                        // New target overrides all
            if (out_d != '0) begin
                state_d = DISCARD;
            end else if (cf_target[1]) begin
                state_d = MISALIGNED_FIRST;
            end else begin
                state_d = RUN;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q    <= RUN;
            discard_q  <= '0;
            mis_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (cf_change) begin
                discard_q  <= out_d;                // Every in-flight answer is stale
                mis_pend_q <= cf_target[1];
            end else if (drop && rsp_recv) begin
                discard_q <= discard_q - req_cnt_t'(1);
            end
        end
    end

    // --------------------
    // Buffer writes and decode side

    assign drop       = (state_q == DISCARD);
    assign misaligned = (state_q == MISALIGNED_FIRST);
    assign f_4byte    = rsp_recv && !drop && !misaligned;
    assign f_2byte    = rsp_recv && misaligned;     // Upper parcel only
    assign s1_valid   = buf_valid;
    assign buf_ready  = buf_valid && !s1_busy;      // Consume this cycle

    frv_core_fetch_buffer u_fetch_buffer (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (s0_flush),
        .f_4byte   (f_4byte),
        .f_2byte   (f_2byte),
        .f_err     (imem_error),
        .f_in      (imem_rdata),
        .buf_ready (buf_ready),
        .f_ready   (f_ready),
        .buf_out   (s1_data),
        .buf_err   (s1_error),
        .buf_valid (buf_valid)
    );

    // --------------------
    // Checks

    // A grant at the limit would wrap the counter unless an answer leaves too
    a_out_limit : assert property (@(posedge g_clk) disable iff (!g_resetn)
        req_fire |-> (out_q < MAX_OUT) || rsp_recv)
        else $error("grant beyond the outstanding request limit");

    a_addr_align : assert property (@(posedge g_clk) disable iff (!g_resetn)
        imem_req |-> (imem_addr[1:0] == 2'b00))
        else $error("fetch address not word aligned");

endmodule

// ==== tests/frv_imem_model.sv ====
// Behavioral instruction memory for the fetch testbench
// Word store loaded by the testbench, LFSR-random grant and response delays,
// random decode stall generator driven from the same LFSR

`timescale 1ns/1ps

module frv_imem_model
    import frv_bus_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       imem_req,
    input  addr_t      imem_addr,
    input  logic       imem_ack,
    output logic       imem_gnt,
    output logic       imem_recv,
    output word_t      imem_rdata,
    output logic       imem_error,
    input  logic [1:0] stall_mode,      // 0 none, 1 short, 2 long stalls
    output logic       rand_busy
);

    addr_t       m_addr [64];
    word_t       m_data [64];
    logic        m_err [64];
    int          m_count = 0;
    logic [31:0] lfsr = 32'hf85b9d19;
    addr_t       pend [$];              // Granted addresses in grant order
    logic        req_s;                 // Bus levels seen before the last rising edge
    addr_t       addr_s;
    logic        ack_s;
    logic [3:0]  gnt_wait;
    logic [3:0]  rsp_wait;
    logic [3:0]  stall_cnt;

    initial begin
        imem_gnt   = 1'b0;
        imem_recv  = 1'b0;
        imem_rdata = '0;
        imem_error = 1'b0;
        rand_busy  = 1'b0;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);         // One step per bit
            v    = {v[2:0], lfsr[0]};
        end
    endtask

    task automatic add_word(input addr_t a, input word_t d, input logic e);
        m_addr[m_count] = a;
        m_data[m_count] = d;
        m_err[m_count]  = e;
        m_count++;
    endtask

    // Unmapped words answer with an error
    task automatic read_word(input addr_t a, output word_t d, output logic e);
        d = '0;
        e = 1'b1;
        for (int i = 0; i < m_count; i++) begin
            if (m_addr[i] == a) begin
                d = m_data[i];
                e = m_err[i];
            end
        end
    endtask

    always @(negedge g_clk) begin : drive_bus
        logic [3:0] r;
        word_t      d;
        logic       e;
        if (!g_resetn) begin
            imem_gnt  = 1'b0;
            imem_recv = 1'b0;
            rand_busy = 1'b0;
            req_s     = 1'b0;
            ack_s     = 1'b0;
            gnt_wait  = '0;
            rsp_wait  = '0;
            stall_cnt = '0;
            pend.delete();
        end else begin
            // --------------------
            // Handshakes of the edge just passed
            if (req_s && imem_gnt) begin
                pend.push_back(addr_s);
            end
            if (imem_recv && ack_s) begin
                imem_recv = 1'b0;
            end
            // --------------------
            // Grant after a random wait
            if (imem_req && gnt_wait == 0) begin
                imem_gnt = 1'b1;
                take_bits(2, r);
                gnt_wait = r;
            end else begin
                imem_gnt = 1'b0;
                if (imem_req) begin
                    gnt_wait = gnt_wait - 1;
                end
            end
            // Responses in grant order, held until acked
            if (!imem_recv && pend.size() > 0) begin
                if (rsp_wait == 0) begin
                    read_word(pend.pop_front(), d, e);
                    imem_recv  = 1'b1;
                    imem_rdata = d;
                    imem_error = e;
                    take_bits(2, r);
                    rsp_wait = r;
                end else begin
                    rsp_wait = rsp_wait - 1;
                end
            end
            // --------------------
            // Decode stalls
            if (stall_cnt != 0) begin
                rand_busy = 1'b1;
                stall_cnt = stall_cnt - 1;
            end else begin
                take_bits(2, r);
                rand_busy = (stall_mode != 0) && (r == 0);
                if (rand_busy && stall_mode == 2) begin
                    take_bits(3, r);
                    stall_cnt = r + 3;              // 4..11 cycles in all
                end
            end
            req_s  = imem_req;
            addr_s = imem_addr;
            ack_s  = imem_ack;
        end
    end

endmodule

// ==== tests/tb_frv_fetch.sv ====
// Testbench for the fetch front end
// Clock and reset, stimulus file reader, redirect sequencing,
// decode-side checker, per-test and closing report

`timescale 1ns/1ps

`include "frv_cfg.svh"

module tb_frv_fetch
    import frv_bus_pkg::*, frv_pipe_pkg::*;
();

    localparam int LIMIT = 2000;        // Cycles allowed per wait

    logic       g_clk;
    logic       g_resetn;
    logic       cf_req;
    addr_t      cf_target;
    logic       cf_ack;
    logic       cf_done;
    logic       imem_req;
    addr_t      imem_addr;
    logic       imem_gnt;
    logic       imem_ack;
    logic       imem_recv;
    logic       imem_error;
    word_t      imem_rdata;
    logic       s0_flush;
    logic       s1_busy;
    logic       s1_valid;
    instr_t     s1_data;
    logic       s1_error;
    logic       hold_decode;            // Freezes decode around a redirect
    logic       rand_busy;
    logic [1:0] stall_mode;

    instr_t     exp_instr [$];
    logic       exp_err [$];
    int         jump_at [$];
    addr_t      jump_to [$];
    int         consumed = 0;
    int         errors = 0;
    int         test_idx = 0;
    int         test_checked [5];
    int         test_errors [5];
    string      test_name [5];

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    assign s0_flush = cf_req && cf_ack;             // Flush with the taken redirect
    assign s1_busy  = hold_decode || rand_busy;

    frv_pipeline_fetch dut_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .cf_req(cf_req), .cf_target(cf_target),
        .cf_ack(cf_ack), .imem_req(imem_req), .imem_addr(imem_addr), .imem_gnt(imem_gnt),
        .imem_ack(imem_ack), .imem_recv(imem_recv), .imem_error(imem_error),
        .imem_rdata(imem_rdata), .s0_flush(s0_flush), .s1_busy(s1_busy),
        .s1_valid(s1_valid), .s1_data(s1_data), .s1_error(s1_error)
    );

    frv_imem_model mem_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_gnt(imem_gnt), .imem_recv(imem_recv),
        .imem_rdata(imem_rdata), .imem_error(imem_error), .stall_mode(stall_mode),
        .rand_busy(rand_busy)
    );

    // --------------------
    // Decode-side checker

    always @(posedge g_clk) begin
        cf_done <= cf_req && cf_ack;
        if (g_resetn && imem_ack && dut_i.u_fetch_buffer.fill_q == `FRV_BUF_HWORDS) begin
            errors++;
            test_errors[test_idx]++;
            $display("ERROR: at %0t the memory was acked while the buffer was full", $time);
        end
        if (g_resetn && s1_valid && !s1_busy) begin
            if (consumed >= exp_instr.size()) begin
                errors++;
                test_errors[test_idx]++;
                $display("ERROR: at %0t an instruction %h arrived past the end", $time, s1_data);
            end else begin
                if (s1_data != exp_instr[consumed]) begin
                    errors++;
                    test_errors[test_idx]++;
                    $display("FAIL %0t s1_data expected %h got %h", $time,
                             exp_instr[consumed], s1_data);
                end
                if (s1_error != exp_err[consumed]) begin
                    errors++;
                    test_errors[test_idx]++;
                    $display("FAIL %0t s1_error expected %b got %b", $time,
                             exp_err[consumed], s1_error);
                end
            end
            test_checked[test_idx]++;
            consumed++;
        end
    end

    // --------------------
    // Helpers

    task automatic load_stimulus();
        int              fd;
        int              n;
        logic [63:0]     tok;
        logic [8*120-1:0] rest;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        fd = $fopen("tests/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the stimulus file could not be opened");
            $display("Verification failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n == 1) begin
                    if (tok == "M") begin
                        n = $fscanf(fd, "%h %h %h", a, b, c);
                        mem_i.add_word(a, b, c[0]);
                    end else if (tok == "J") begin
                        n = $fscanf(fd, "%d %h", a, b);
                        jump_at.push_back(a);
                        jump_to.push_back(b);
                    end else if (tok == "E") begin
                        n = $fscanf(fd, "%h %h", a, b);
                        exp_instr.push_back(a);
                        exp_err.push_back(b[0]);
                    end else begin
                        n = $fgets(rest, fd);       // Comment line
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Returns at the falling edge where the count is reached
    task automatic wait_consumed(input int n);
        int cycles;
        cycles = 0;
        while (consumed < n && cycles <= LIMIT) begin
            @(negedge g_clk);
            cycles++;
        end
        if (consumed < n) begin
            $display("ERROR: timeout, only %0d of %0d instructions arrived", consumed, n);
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic wait_redirect();
        int cycles;
        cycles = 0;
        while (!cf_done && cycles <= LIMIT) begin
            @(negedge g_clk);
            cycles++;
        end
        if (!cf_done) begin
            $display("ERROR: timeout, the control flow change was never acknowledged");
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic report_test(input int idx);
        $display("test %0d %s: %0d checked, %0d errors, %s", idx + 1, test_name[idx],
                 test_checked[idx], test_errors[idx], (test_errors[idx] == 0) ? "ok" : "bad");
    endtask

    // --------------------
    // Main sequence

    initial begin : main
        g_resetn    = 1'b0;
        cf_req      = 1'b0;
        cf_target   = '0;
        cf_done     = 1'b0;
        hold_decode = 1'b0;
        stall_mode  = 2'd1;
        test_name   = '{"sequential stream", "redirect", "misaligned target",
                        "back-pressure", "error propagation"};
        for (int i = 0; i < 5; i++) begin
            test_checked[i] = 0;
            test_errors[i]  = 0;
        end
        load_stimulus();
        repeat (2) @(negedge g_clk);
        g_resetn = 1'b1;
        for (int k = 0; k < jump_at.size(); k++) begin
            wait_consumed(jump_at[k]);
            hold_decode = 1'b1;                     // Nothing old slips past the jump
            cf_target   = jump_to[k];
            cf_req      = 1'b1;
            wait_redirect();
            cf_req      = 1'b0;
            hold_decode = 1'b0;
            report_test(test_idx);
            test_idx++;
            stall_mode = (test_idx == 3) ? 2'd2 : 2'd1;   // Long stalls for back-pressure
        end
        wait_consumed(exp_instr.size());
        hold_decode = 1'b1;
        repeat (20) @(negedge g_clk);               // Let late errors show
        report_test(test_idx);
        $display("tests %0d, instructions %0d, errors %0d", test_idx + 1, consumed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tests/fetch_stimulus.txt ====
# M address data error / J consumed-count target / E instruction error
# Sequential stream, 32-bit instructions straddling words
M 80000000 00934505 0
M 80000004 80820010 0
M 80000008 00200113 0
M 8000000c 00300193 0
M 80000010 02134611 0
M 80000014 05050040 0
E 00004505 0
E 00100093 0
E 00008082 0
E 00200113 0
E 00300193 0
E 00004611 0
E 00400213 0
E 00000505 0
# Redirect to an aligned target
J 8 80000100
M 80000100 00500293 0
M 80000104 03134681 0
M 80000108 47010060 0
E 00500293 0
E 00004681 0
E 00600313 0
E 00004701 0
# Misaligned target, lower half of the first word is dropped
J 12 80000202
M 80000200 4785ffff 0
M 80000204 00700393 0
M 80000208 04134801 0
M 8000020c 48850080 0
E 00004785 0
E 00700393 0
E 00004801 0
E 00800413 0
E 00004885 0
# Back-pressure under long decode stalls
J 17 80000300
M 80000300 00900493 0
M 80000304 00a00513 0
M 80000308 49254911 0
M 8000030c 00b00593 0
M 80000310 061349a1 0
M 80000314 4a0500c0 0
M 80000318 00d00693 0
E 00900493 0
E 00a00513 0
E 00004911 0
E 00004925 0
E 00b00593 0
E 000049a1 0
E 00c00613 0
E 00004a05 0
E 00d00693 0
# Error propagation from an errored word
J 26 80000400
M 80000400 00e00713 0
M 80000404 07934b05 0
M 80000408 4b8900f0 1
M 8000040c 01000813 0
E 00e00713 0
E 00004b05 0
E 00f00793 1
E 00004b89 1
E 01000813 0

// ==== verilog.f ====
+incdir+include
rtl/frv_bus_pkg.sv
rtl/frv_pipe_pkg.sv
rtl/frv_core_fetch_buffer.sv
rtl/frv_pipeline_fetch.sv
tests/frv_imem_model.sv
tests/tb_frv_fetch.sv
